// ==== common/rv_exec_pkg.sv ====
// shared widths, instruction views, alu op codes and pipeline structs for the rv32i exec slice
`default_nettype none

package rv_exec_pkg;

  // data word width
  localparam int xlen = 32;

  // major opcodes the decoder accepts
  localparam logic [6:0] op_reg = 7'b0110011;
  localparam logic [6:0] op_imm = 7'b0010011;
  localparam logic [6:0] op_lui = 7'b0110111;

  // register-register format
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  // register-immediate format
  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // upper immediate format
  typedef struct packed {
    logic [19:0] imm20;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  // one instruction word, three ways to look at it
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    u_fmt_t u;
  } inst_t;

  typedef enum logic [3:0] {
    alu_add  = 4'd0,
    alu_sub  = 4'd1,
    alu_and  = 4'd2,
    alu_or   = 4'd3,
    alu_xor  = 4'd4,
    alu_sll  = 4'd5,
    alu_srl  = 4'd6,
    alu_sra  = 4'd7,
    alu_slt  = 4'd8,
    alu_sltu = 4'd9
  } alu_op_e;

  // decoded instruction handed to the execute stage
  typedef struct packed {
    alu_op_e         op;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic [xlen-1:0] imm;
    logic            use_imm;
    logic            is_lui;
    logic            illegal;
  } dec_t;

  // retired result, also the writeback payload
  typedef struct packed {
    logic [4:0]      rd;
    logic [xlen-1:0] data;
    logic            illegal;
  } wb_t;

endpackage

`default_nettype wire

// ==== alu/alu_unit.sv ====
// combinational integer alu, picks one candidate result by matching op against a key table
`default_nettype none
`timescale 1ns/1ps

module alu_unit
  import rv_exec_pkg::*;
(
  input  alu_op_e         op,
  input  logic [xlen-1:0] a,
  input  logic [xlen-1:0] b,
  output logic [xlen-1:0] y
);

  localparam int nr_key = 10;
  localparam logic [xlen-1:0] default_y = '0;

  // key n selects cand[n]
  localparam alu_op_e op_keys [nr_key] = '{
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_slt,
    alu_sltu
  };

  logic [xlen-1:0] cand [nr_key];
  logic [4:0]      shamt;
  logic [xlen-1:0] sel;
  logic            hit;

  // only the low five bits shift
  assign shamt = b[4:0];

  assign cand[0] = a + b;
  assign cand[1] = a - b;
  assign cand[2] = a & b;
  assign cand[3] = a | b;
  assign cand[4] = a ^ b;
  assign cand[5] = a << shamt;
  assign cand[6] = a >> shamt;
  assign cand[7] = $unsigned($signed(a) >>> shamt);
  assign cand[8] = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
  assign cand[9] = {{(xlen-1){1'b0}}, a < b};

  // and-or merge of all matching entries
  always_comb begin
    sel = '0;
    hit = 1'b0;
    for (int n = 0; n < nr_key; n++) begin
      sel = sel | ({xlen{op == op_keys[n]}} & cand[n]);
      hit = hit | (op == op_keys[n]);
    end
  end

  // no key match falls back to zero
  assign y = hit ? sel : default_y;

endmodule

`default_nettype wire

// ==== verilog/reg_file.sv ====
// two read, one write register file, x0 always reads as zero
`default_nettype none
`timescale 1ns/1ps

module reg_file
  import rv_exec_pkg::*;
#(
  parameter int reg_addr_width = 5
) (
  input  logic            clk,
  input  logic [4:0]      raddr_a,
  input  logic [4:0]      raddr_b,
  output logic [xlen-1:0] rdata_a,
  output logic [xlen-1:0] rdata_b,
  input  logic            wen,
  input  logic [4:0]      waddr,
  input  logic [xlen-1:0] wdata
);

  localparam int num_regs = 1 << reg_addr_width;

  logic [xlen-1:0] regs [num_regs];

  // decoder rejects indices above the implemented range
  assign rdata_a = (raddr_a == 5'd0) ? '0 : regs[raddr_a[reg_addr_width-1:0]];
  assign rdata_b = (raddr_b == 5'd0) ? '0 : regs[raddr_b[reg_addr_width-1:0]];

  always_ff @(posedge clk) begin
    if (wen) begin
      regs[waddr[reg_addr_width-1:0]] <= wdata;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/inst_decoder.sv ====
// input stage, decodes each strobed instruction word into a registered dec_t for execute
`default_nettype none
`timescale 1ns/1ps

module inst_decoder
  import rv_exec_pkg::*;
#(
  parameter int reg_addr_width = 5
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  inst_valid,
  input  inst_t inst,
  output logic  dec_valid,
  output dec_t  dec
);

  localparam int num_regs = 1 << reg_addr_width;

  // funct7 values for the base op and the alternate (sub, sra)
  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt  = 7'b0100000;

  dec_t dec_next;
  logic op_ok;
  logic regs_ok;

  // rv32e style configs only implement the lower half
  function automatic logic reg_in_range(input logic [4:0] idx);
    return int'(idx) < num_regs;
  endfunction

  always_comb begin
    dec_next    = '0;
    dec_next.op = alu_add;
    op_ok       = 1'b0;

    case (inst.r.opcode)
      op_reg: begin
        dec_next.rs1 = inst.r.rs1;
        dec_next.rs2 = inst.r.rs2;
        dec_next.rd  = inst.r.rd;
        op_ok        = 1'b1;
        case ({inst.r.funct7, inst.r.funct3})
          {f7_base, 3'b000}: dec_next.op = alu_add;
          {f7_alt,  3'b000}: dec_next.op = alu_sub;
          {f7_base, 3'b001}: dec_next.op = alu_sll;
          {f7_base, 3'b010}: dec_next.op = alu_slt;
          {f7_base, 3'b011}: dec_next.op = alu_sltu;
          {f7_base, 3'b100}: dec_next.op = alu_xor;
          {f7_base, 3'b101}: dec_next.op = alu_srl;
          {f7_alt,  3'b101}: dec_next.op = alu_sra;
          {f7_base, 3'b110}: dec_next.op = alu_or;
          {f7_base, 3'b111}: dec_next.op = alu_and;
          default:           op_ok       = 1'b0;
        endcase
      end

      op_imm: begin
        dec_next.rs1     = inst.i.rs1;
        dec_next.rd      = inst.i.rd;
        dec_next.imm     = {{(xlen-12){inst.i.imm12[11]}}, inst.i.imm12};
        dec_next.use_imm = 1'b1;
        op_ok            = 1'b1;
        case (inst.i.funct3)
          3'b000: dec_next.op = alu_add;
          3'b010: dec_next.op = alu_slt;
          3'b011: dec_next.op = alu_sltu;
          3'b100: dec_next.op = alu_xor;
          3'b110: dec_next.op = alu_or;
          3'b111: dec_next.op = alu_and;
          3'b001: begin
            dec_next.op = alu_sll;
            op_ok       = (inst.i.imm12[11:5] == f7_base);
          end
          // upper imm bits pick logical or arithmetic right shift
          3'b101: begin
            if (inst.i.imm12[11:5] == f7_base) begin
              dec_next.op = alu_srl;
            end else if (inst.i.imm12[11:5] == f7_alt) begin
              dec_next.op = alu_sra;
            end else begin
              op_ok = 1'b0;
            end
          end
          default: op_ok = 1'b0;
        endcase
      end

      // lui is add of zero and the shifted immediate
      op_lui: begin
        dec_next.rd      = inst.u.rd;
        dec_next.imm     = {inst.u.imm20, 12'b0};
        dec_next.use_imm = 1'b1;
        dec_next.is_lui  = 1'b1;
        op_ok            = 1'b1;
      end

      default: op_ok = 1'b0;
    endcase

    // unused source fields stay at x0, always in range
    regs_ok = reg_in_range(dec_next.rd) && reg_in_range(dec_next.rs1) &&
              reg_in_range(dec_next.rs2);
    dec_next.illegal = !(op_ok && regs_ok);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= inst_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (inst_valid) begin
      dec <= dec_next;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/exec_stage.sv ====
// execute stage, reads operands with forwarding, runs the alu and holds the result that writes back
`default_nettype none
`timescale 1ns/1ps

module exec_stage
  import rv_exec_pkg::*;
#(
  parameter int reg_addr_width = 5
) (
  input  logic clk,
  input  logic rst,
  input  logic dec_valid,
  input  dec_t dec,
  output logic result_valid,
  output wb_t  result
);

  logic [xlen-1:0] rdata_a;
  logic [xlen-1:0] rdata_b;
  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;
  logic [xlen-1:0] alu_y;
  logic            wen;
  logic            fwd_a;
  logic            fwd_b;

  // writeback straight from the result register
  assign wen = result_valid && !result.illegal && (result.rd != 5'd0);

  reg_file #(
    .reg_addr_width(reg_addr_width)
  ) rf0 (
    .clk    (clk),
    .raddr_a(dec.rs1),
    .raddr_b(dec.rs2),
    .rdata_a(rdata_a),
    .rdata_b(rdata_b),
    .wen    (wen),
    .waddr  (result.rd),
    .wdata  (result.data)
  );

  // the register file write lands one edge too late for the next instruction
  assign fwd_a = wen && (result.rd == dec.rs1);
  assign fwd_b = wen && (result.rd == dec.rs2);

  always_comb begin
    if (dec.is_lui) begin
      op_a = '0;
    end else if (fwd_a) begin
      op_a = result.data;
    end else begin
      op_a = rdata_a;
    end
  end

  always_comb begin
    if (dec.use_imm) begin
      op_b = dec.imm;
    end else if (fwd_b) begin
      op_b = result.data;
    end else begin
      op_b = rdata_b;
    end
  end

  alu_unit alu0 (
    .op(dec.op),
    .a (op_a),
    .b (op_b),
    .y (alu_y)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= dec_valid;
    end
  end

  // illegal words retire with zero data
  always_ff @(posedge clk) begin
    if (dec_valid) begin
      result.rd      <= dec.rd;
      result.data    <= dec.illegal ? '0 : alu_y;
      result.illegal <= dec.illegal;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/exec_core.sv ====
// top level of the rv32i exec slice, decoder feeding the execute stage, two cycle latency
`default_nettype none
`timescale 1ns/1ps

module exec_core
  import rv_exec_pkg::*;
#(
  // 5 for rv32i, 4 for rv32e
  parameter int reg_addr_width = 5
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  inst_valid,
  input  inst_t inst,
  output logic  result_valid,
  output wb_t   result
);

  logic dec_valid;
  dec_t dec;

  inst_decoder #(
    .reg_addr_width(reg_addr_width)
  ) decoder0 (
    .clk       (clk),
    .rst       (rst),
    .inst_valid(inst_valid),
    .inst      (inst),
    .dec_valid (dec_valid),
    .dec       (dec)
  );

  exec_stage #(
    .reg_addr_width(reg_addr_width)
  ) stage0 (
    .clk         (clk),
    .rst         (rst),
    .dec_valid   (dec_valid),
    .dec         (dec),
    .result_valid(result_valid),
    .result      (result)
  );

endmodule

`default_nettype wire

// ==== testbench/exec_core_assert.sv ====
// concurrent checks on exec_core result timing and illegal data, attached by bind
`default_nettype none
`timescale 1ns/1ps

module exec_core_assert
  import rv_exec_pkg::*;
(
  input logic clk,
  input logic rst,
  input logic inst_valid,
  input logic result_valid,
  input wb_t  result
);

  // nothing retires straight out of reset
  rst_clears_valid: assert property (@(posedge clk) rst |=> !result_valid)
    else $error("result_valid high in the cycle after reset");

  // fixed two cycle latency, one pulse per strobe
  latency_two: assert property (@(posedge clk) disable iff (rst)
    result_valid == $past(inst_valid, 2))
    else $error("result_valid does not follow inst_valid by two cycles");

  illegal_zero_data: assert property (@(posedge clk) disable iff (rst)
    result_valid && result.illegal |-> result.data == '0)
    else $error("illegal result carries nonzero data");

endmodule

bind exec_core exec_core_assert assert0 (
  .clk         (clk),
  .rst         (rst),
  .inst_valid  (inst_valid),
  .result_valid(result_valid),
  .result      (result)
);

`default_nettype wire

// ==== testbench/exec_core_tb.sv ====
// testbench for exec_core, seeded random rv32i stream checked against a register model
`default_nettype none
`timescale 1ns/1ps

module exec_core_tb;
  import rv_exec_pkg::*;

  logic            clk;
  logic            rst;
  logic            inst_valid;
  inst_t           inst;
  logic            result_valid;
  wb_t             result;
  logic [xlen-1:0] regs [32];
  wb_t             exp_q [$];
  logic [1:0]      valid_pipe;
  int              errors;
  int              err_mark;
  int              tests_passed;
  int              tests_failed;

  exec_core dut0 (
    .clk         (clk),
    .rst         (rst),
    .inst_valid  (inst_valid),
    .inst        (inst),
    .result_valid(result_valid),
    .result      (result)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic inst_t encode_r(input logic [6:0] f7, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3,
                                     input logic [4:0] rd);
    inst_t w;
    w.r = '{f7, rs2, rs1, f3, rd, op_reg};
    return w;
  endfunction

  function automatic inst_t encode_i(input logic [11:0] imm, input logic [4:0] rs1,
                                     input logic [2:0] f3, input logic [4:0] rd);
    inst_t w;
    w.i = '{imm, rs1, f3, rd, op_imm};
    return w;
  endfunction

  function automatic logic [4:0] rand_reg();
    return 5'($urandom_range(31, 1));
  endfunction

  task automatic check_wb(input wb_t got, input wb_t exp);
    if (got !== exp) begin
      $display("Error: result rd=%h data=%h illegal=%h, expected rd=%h data=%h illegal=%h",
               got.rd, got.data, got.illegal, exp.rd, exp.data, exp.illegal);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error: %s=%h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  // executes in program order at issue time, queues the expected retirement
  task automatic model_issue(input inst_t w);
    wb_t             e;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [2:0]      f3;
    logic            alt;
    logic            ok;
    logic            known;
    f3    = w.r.funct3;
    alt   = (w.r.funct7 == 7'h20);
    known = (w.r.opcode == op_reg) || (w.r.opcode == op_imm) || (w.r.opcode == op_lui);
    a     = regs[w.r.rs1];
    b     = (w.r.opcode == op_reg) ? regs[w.r.rs2] : {{20{w.i.imm12[11]}}, w.i.imm12};
    if (w.r.opcode == op_reg) begin
      ok = (w.r.funct7 == 7'h00) || (alt && (f3 == 3'd0 || f3 == 3'd5));
    end else if (w.r.opcode == op_imm && (f3 == 3'd1 || f3 == 3'd5)) begin
      ok = (w.r.funct7 == 7'h00) || (alt && f3 == 3'd5);
    end else begin
      ok = known;
    end
    case (f3)
      3'd0: e.data = (w.r.opcode == op_reg && alt) ? a - b : a + b;
      3'd1: e.data = a << b[4:0];
      3'd2: e.data = {31'd0, $signed(a) < $signed(b)};
      3'd3: e.data = {31'd0, a < b};
      3'd4: e.data = a ^ b;
      3'd5: begin
        if (alt) e.data = $unsigned($signed(a) >>> b[4:0]);
        else e.data = a >> b[4:0];
      end
      3'd6: e.data = a | b;
      default: e.data = a & b;
    endcase
    if (w.r.opcode == op_lui) e.data = {w.u.imm20, 12'h000};
    if (!ok) e.data = '0;
    // unknown opcodes have no register fields to report
    e.rd      = known ? w.r.rd : 5'd0;
    e.illegal = !ok;
    if (ok && e.rd != 5'd0) regs[e.rd] = e.data;
    exp_q.push_back(e);
  endtask

  // outputs come from flops, so they are stable at the falling edge
  task automatic monitor_output();
    valid_pipe = {valid_pipe[0], inst_valid};
    check_bit("result_valid", result_valid, valid_pipe[1]);
    if (result_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("a result appeared with no instruction pending");
        errors++;
      end else begin
        check_wb(result, exp_q.pop_front());
      end
    end
  endtask

  task automatic step(input logic v, input inst_t w);
    @(negedge clk);
    monitor_output();
    inst_valid = v;
    inst       = w;
    if (v) model_issue(w);
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 10) begin
      step(1'b0, '0);
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("timed out with %0d results still missing", exp_q.size());
      errors += exp_q.size();
      exp_q.delete();
    end
  endtask

  task automatic end_test(input string name);
    if (errors == err_mark) begin
      $display("test %s passed", name);
      tests_passed++;
    end else begin
      $display("test %s failed with %0d errors", name, errors - err_mark);
      tests_failed++;
    end
    err_mark = errors;
  endtask

  initial begin
    inst_t      w;
    logic [2:0] f3;
    logic [4:0] prev;
    logic [4:0] nxt;
    void'($urandom(71));
    rst        = 1'b1;
    inst_valid = 1'b0;
    inst       = '0;
    valid_pipe = '0;
    errors     = 0;
    err_mark   = 0;
    tests_passed = 0;
    tests_failed = 0;
    foreach (regs[i]) regs[i] = '0;
    repeat (2) @(negedge clk);
    rst = 1'b0;

    repeat (5) step(1'b0, '0);
    end_test("idle_after_reset");

    for (int r = 1; r < 32; r++) step(1'b1, encode_i(12'($urandom), 5'd0, 3'd0, 5'(r)));
    drain();
    end_test("preload");

    repeat (40) begin
      f3 = 3'($urandom);
      w  = encode_r(((f3 == 3'd0 || f3 == 3'd5) && $urandom % 2 == 1) ? 7'h20 : 7'h00,
                    rand_reg(), rand_reg(), f3, rand_reg());
      step(1'b1, w);
      if ($urandom % 3 == 0) step(1'b0, '0);
    end
    drain();
    end_test("reg_reg");

    repeat (40) begin
      f3 = 3'($urandom);
      w  = encode_i(12'($urandom), rand_reg(), f3, rand_reg());
      if (f3 == 3'd1) w.i.imm12[11:5] = 7'h00;
      if (f3 == 3'd5) w.i.imm12[11:5] = ($urandom % 2 == 1) ? 7'h20 : 7'h00;
      if ($urandom % 5 == 0) w.u = '{20'($urandom), rand_reg(), op_lui};
      step(1'b1, w);
    end
    drain();
    end_test("reg_imm_lui");

    repeat (8) begin
      step(1'b1, encode_r(7'h00, rand_reg(), rand_reg(), 3'($urandom), 5'd0));
      step(1'b1, encode_r(7'h00, 5'd0, 5'd0, 3'd6, rand_reg()));
      step(1'b1, encode_i(12'($urandom), 5'd0, 3'd0, rand_reg()));
    end
    drain();
    end_test("x0_write");

    prev = rand_reg();
    step(1'b1, encode_i(12'($urandom), 5'd0, 3'd0, prev));
    repeat (20) begin
      nxt = rand_reg();
      step(1'b1, encode_r(7'h00, ($urandom % 2 == 1) ? prev : rand_reg(), prev,
                          3'($urandom), nxt));
      prev = nxt;
    end
    drain();
    end_test("forward_chain");

    repeat (10) begin
      case ($urandom % 3)
        0: begin
          w = $urandom;
          if (w.r.opcode == op_reg || w.r.opcode == op_imm || w.r.opcode == op_lui) begin
            w.r.opcode = 7'h7f;
          end
        end
        1: w = encode_r(7'h01, rand_reg(), rand_reg(), 3'($urandom), rand_reg());
        default: w = encode_i({7'h10, 5'($urandom)}, rand_reg(), 3'd1, rand_reg());
      endcase
      step(1'b1, w);
      step(1'b1, encode_r(7'h00, 5'd0, w.r.rd, 3'd6, rand_reg()));
    end
    drain();
    end_test("illegal");

    $display("tests passed %0d failed %0d, errors %0d", tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
common/rv_exec_pkg.sv
alu/alu_unit.sv
verilog/reg_file.sv
verilog/inst_decoder.sv
verilog/exec_stage.sv
verilog/exec_core.sv
testbench/exec_core_assert.sv
testbench/exec_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the exec_core testbench with verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module exec_core_tb -f build.f -o sim_exec_core
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_exec_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation failed" sim.log; then
  exit 1
fi
exit 0
